/* control_unit.f */
design/riscv_ctrl_pkg.sv
design/decode_control.sv
design/alu_control.sv
design/branch_controller.sv
design/forwarding_unit.sv
design/hazard_handler.sv
design/pipeline_controller.sv
design/control_unit.sv
verif/tb_clock_gen.sv
verif/control_unit_properties.sv
verif/tb_control_unit.sv

/* design/alu_control.sv */
`timescale 1ns/1ps

module alu_control (
  input  logic [2:0]             fun3,
  input  logic [6:0]             fun7,
  input  riscv_ctrl_pkg::alu_op_t alu_op,
  output riscv_ctrl_pkg::alu_t    alu_ctrl,
  output logic                   m_type,
  output logic                   divide_instruction
);

  // shared R/I decode, alt_sub only matters for register ops
  function automatic riscv_ctrl_pkg::alu_t base_op(
    input logic [2:0] f3,
    input logic       alt_sub,
    input logic       alt_sra
  );
    case (f3)
      3'd0:    base_op = alt_sub ? riscv_ctrl_pkg::SUB : riscv_ctrl_pkg::ADD;
      3'd1:    base_op = riscv_ctrl_pkg::SLL;
      3'd2:    base_op = riscv_ctrl_pkg::SLT;
      3'd3:    base_op = riscv_ctrl_pkg::SLTU;
      3'd4:    base_op = riscv_ctrl_pkg::XOR;
      3'd5:    base_op = alt_sra ? riscv_ctrl_pkg::SRA : riscv_ctrl_pkg::SRL;
      3'd6:    base_op = riscv_ctrl_pkg::OR;
      default: base_op = riscv_ctrl_pkg::AND;
    endcase
  endfunction

  function automatic riscv_ctrl_pkg::alu_t muldiv_op(input logic [2:0] f3);
    case (f3)
      3'd0:    muldiv_op = riscv_ctrl_pkg::MUL;
      3'd1:    muldiv_op = riscv_ctrl_pkg::MULH;
      3'd2:    muldiv_op = riscv_ctrl_pkg::MULHSU;
      3'd3:    muldiv_op = riscv_ctrl_pkg::MULHU;
      3'd4:    muldiv_op = riscv_ctrl_pkg::DIV;
      3'd5:    muldiv_op = riscv_ctrl_pkg::DIVU;
      3'd6:    muldiv_op = riscv_ctrl_pkg::REM;
      default: muldiv_op = riscv_ctrl_pkg::REMU;
    endcase
  endfunction

  always_comb begin
    alu_ctrl           = riscv_ctrl_pkg::ADD;
    m_type             = 1'b0;
    divide_instruction = 1'b0;
    case (alu_op)
      riscv_ctrl_pkg::ALUOP_BRANCH: begin
        // compare through subtract or set-less-than
        case (riscv_ctrl_pkg::branch_t'(fun3))
          riscv_ctrl_pkg::BEQ, riscv_ctrl_pkg::BNE:   alu_ctrl = riscv_ctrl_pkg::SUB;
          riscv_ctrl_pkg::BLT, riscv_ctrl_pkg::BGE:   alu_ctrl = riscv_ctrl_pkg::SLT;
          riscv_ctrl_pkg::BLTU, riscv_ctrl_pkg::BGEU: alu_ctrl = riscv_ctrl_pkg::SLTU;
          default:                                    alu_ctrl = riscv_ctrl_pkg::ADD;
        endcase
      end
      riscv_ctrl_pkg::ALUOP_R: begin
        if (fun7 == riscv_ctrl_pkg::FUN7_MULDIV) begin
          alu_ctrl           = muldiv_op(fun3);
          m_type             = 1'b1;
          // div, divu, rem and remu go to the divider
          divide_instruction = fun3[2];
        end else begin
          alu_ctrl = base_op(fun3, fun7[5], fun7[5]);
        end
      end
      riscv_ctrl_pkg::ALUOP_I: alu_ctrl = base_op(fun3, 1'b0, fun7[5]);
      default:                 alu_ctrl = riscv_ctrl_pkg::ADD;
    endcase
  end

endmodule

/* design/branch_controller.sv */
`timescale 1ns/1ps

module branch_controller (
  input  riscv_ctrl_pkg::branch_t fun3,
  input  logic                   branch,
  input  logic                   jump,
  input  logic                   zero,
  output logic                   pc_sel
);

  logic taken;

  // for the slt forms the alu result is 1 when less, so zero low means true
  always_comb begin
    case (fun3)
      riscv_ctrl_pkg::BEQ:  taken = zero;
      riscv_ctrl_pkg::BNE:  taken = !zero;
      riscv_ctrl_pkg::BLT:  taken = !zero;
      riscv_ctrl_pkg::BLTU: taken = !zero;
      riscv_ctrl_pkg::BGE:  taken = zero;
      riscv_ctrl_pkg::BGEU: taken = zero;
      default:              taken = 1'b0;
    endcase
  end

  assign pc_sel = jump | (branch & taken);

endmodule

/* design/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic [6:0]                   opcode_id,
  input  logic [6:0]                   fun7_exe,
  input  logic [2:0]                   fun3_exe,
  input  logic [2:0]                   fun3_mem,
  input  logic                         zero_mem,
  input  riscv_ctrl_pkg::alu_op_t       alu_op_exe,
  input  logic                         jump_mem,
  input  logic                         branch_mem,
  input  logic                         interrupt,
  input  logic                         divide_stall,
  input  logic                         stall_pipl,
  input  logic [4:0]                   rs1_id,
  input  logic [4:0]                   rs2_id,
  input  logic [4:0]                   rs1_exe,
  input  logic [4:0]                   rs2_exe,
  input  logic [4:0]                   rs2_mem,
  input  logic [4:0]                   rd_exe,
  input  logic [4:0]                   rd_mem,
  input  logic [4:0]                   rd_wb,
  input  logic                         reg_write_mem,
  input  logic                         reg_write_wb,
  input  riscv_ctrl_pkg::wb_sel_t       mem_to_reg_exe,
  output riscv_ctrl_pkg::decode_ctrl_t  dec,
  output logic                         invalid_inst,
  output riscv_ctrl_pkg::alu_t          alu_ctrl_exe,
  output logic                         m_type_exe,
  output logic                         divide_instruction,
  output logic                         pc_sel_mem,
  output riscv_ctrl_pkg::fwd_ctrl_t     fwd,
  output logic                         load_hazard,
  output riscv_ctrl_pkg::pipe_ctrl_t    pipe
);

  logic use_rs1_id;
  logic use_rs2_id;

  decode_control dec_ctrl_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .opcode       (opcode_id),
    .advance      (pipe.id_exe_en & ~pipe.id_exe_clr),
    .clear        (pc_sel_mem | interrupt),
    .ctrl         (dec),
    .invalid_inst (invalid_inst)
  );

  // lui and auipc take no register source, stores read rs2 as data
  assign use_rs1_id = ~(dec.lui | dec.auipc);
  assign use_rs2_id = dec.r_type | dec.branch | (opcode_id == riscv_ctrl_pkg::OP_STORE);

  alu_control alu_ctrl_inst (
    .fun3               (fun3_exe),
    .fun7               (fun7_exe),
    .alu_op             (alu_op_exe),
    .alu_ctrl           (alu_ctrl_exe),
    .m_type             (m_type_exe),
    .divide_instruction (divide_instruction)
  );

  branch_controller branch_ctrl_inst (
    .fun3   (riscv_ctrl_pkg::branch_t'(fun3_mem)),
    .branch (branch_mem),
    .jump   (jump_mem),
    .zero   (zero_mem),
    .pc_sel (pc_sel_mem)
  );

  forwarding_unit fwd_inst (
    .rs1_id        (rs1_id),
    .rs2_id        (rs2_id),
    .rs1_exe       (rs1_exe),
    .rs2_exe       (rs2_exe),
    .rs2_mem       (rs2_mem),
    .rd_mem        (rd_mem),
    .rd_wb         (rd_wb),
    .reg_write_mem (reg_write_mem),
    .reg_write_wb  (reg_write_wb),
    .fwd           (fwd)
  );

  hazard_handler hazard_inst (
    .rs1_id         (rs1_id),
    .rs2_id         (rs2_id),
    .rd_exe         (rd_exe),
    .use_rs1        (use_rs1_id),
    .use_rs2        (use_rs2_id),
    .mem_to_reg_exe (mem_to_reg_exe),
    .load_hazard    (load_hazard)
  );

  // a taken branch or jump in memory acts as the branch hazard
  pipeline_controller pipe_ctrl_inst (
    .stall_pipl    (stall_pipl),
    .divide_stall  (divide_stall),
    .branch_hazard (pc_sel_mem),
    .load_hazard   (load_hazard),
    .pipe          (pipe)
  );

endmodule

/* design/decode_control.sv */
`timescale 1ns/1ps

module decode_control (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic [6:0]                  opcode,
  // instruction moves from decode into execute this cycle
  input  logic                        advance,
  // redirect or interrupt drops the invalid flag
  input  logic                        clear,
  output riscv_ctrl_pkg::decode_ctrl_t ctrl,
  output logic                        invalid_inst
);

  logic opcode_valid;

  always_comb begin
    ctrl         = '0;
    opcode_valid = 1'b1;
    case (opcode)
      riscv_ctrl_pkg::OP_R: begin
        ctrl.reg_write = 1'b1;
        ctrl.r_type    = 1'b1;
        ctrl.alu_op    = riscv_ctrl_pkg::ALUOP_R;
      end
      riscv_ctrl_pkg::OP_I: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
        ctrl.alu_op    = riscv_ctrl_pkg::ALUOP_I;
      end
      riscv_ctrl_pkg::OP_LOAD: begin
        ctrl.reg_write  = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.mem_to_reg = riscv_ctrl_pkg::WB_MEM;
      end
      riscv_ctrl_pkg::OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      riscv_ctrl_pkg::OP_BRANCH: begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = riscv_ctrl_pkg::ALUOP_BRANCH;
      end
      riscv_ctrl_pkg::OP_JAL: begin
        ctrl.jump       = 1'b1;
        ctrl.jal        = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = riscv_ctrl_pkg::WB_PC4;
      end
      riscv_ctrl_pkg::OP_JALR: begin
        ctrl.jump       = 1'b1;
        ctrl.alu_src    = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = riscv_ctrl_pkg::WB_PC4;
      end
      riscv_ctrl_pkg::OP_LUI: begin
        ctrl.lui       = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      riscv_ctrl_pkg::OP_AUIPC: begin
        ctrl.auipc     = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.alu_src   = 1'b1;
      end
      riscv_ctrl_pkg::OP_SYSTEM: begin
        ctrl.csr_type   = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = riscv_ctrl_pkg::WB_CSR;
      end
      default: opcode_valid = 1'b0;
    endcase
  end

  // sticky until the pipeline is redirected, clear has priority
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      invalid_inst <= 1'b0;
    end else if (clear) begin
      invalid_inst <= 1'b0;
    end else if (advance && !opcode_valid) begin
      invalid_inst <= 1'b1;
    end
  end

endmodule

/* design/forwarding_unit.sv */
`timescale 1ns/1ps

module forwarding_unit (
  input  logic [4:0]               rs1_id,
  input  logic [4:0]               rs2_id,
  input  logic [4:0]               rs1_exe,
  input  logic [4:0]               rs2_exe,
  input  logic [4:0]               rs2_mem,
  input  logic [4:0]               rd_mem,
  input  logic [4:0]               rd_wb,
  input  logic                     reg_write_mem,
  input  logic                     reg_write_wb,
  output riscv_ctrl_pkg::fwd_ctrl_t fwd
);

  function automatic logic hit(input logic we, input logic [4:0] rd, input logic [4:0] rs);
    hit = we && (rd != riscv_ctrl_pkg::REG_ZERO) && (rd == rs);
  endfunction

  // memory stage is younger, so it wins over writeback
  function automatic riscv_ctrl_pkg::fwd_sel_t exe_sel(input logic [4:0] rs);
    if (hit(reg_write_mem, rd_mem, rs)) begin
      exe_sel = riscv_ctrl_pkg::FWD_MEM;
    end else if (hit(reg_write_wb, rd_wb, rs)) begin
      exe_sel = riscv_ctrl_pkg::FWD_WB;
    end else begin
      exe_sel = riscv_ctrl_pkg::FWD_NONE;
    end
  endfunction

  always_comb begin
    fwd.rd1_id  = hit(reg_write_wb, rd_wb, rs1_id);
    fwd.rd2_id  = hit(reg_write_wb, rd_wb, rs2_id);
    fwd.rd1_exe = exe_sel(rs1_exe);
    fwd.rd2_exe = exe_sel(rs2_exe);
    // store data in memory can still pick up the writeback value
    fwd.rd2_mem = hit(reg_write_wb, rd_wb, rs2_mem);
  end

endmodule

/* design/hazard_handler.sv */
`timescale 1ns/1ps

module hazard_handler (
  input  logic [4:0]             rs1_id,
  input  logic [4:0]             rs2_id,
  input  logic [4:0]             rd_exe,
  input  logic                   use_rs1,
  input  logic                   use_rs2,
  input  riscv_ctrl_pkg::wb_sel_t mem_to_reg_exe,
  output logic                   load_hazard
);

  logic late_result;
  logic rs1_match;
  logic rs2_match;

  // loads and csr reads have no result until memory
  assign late_result = (mem_to_reg_exe == riscv_ctrl_pkg::WB_MEM) ||
                       (mem_to_reg_exe == riscv_ctrl_pkg::WB_CSR);

  assign rs1_match = use_rs1 && (rd_exe == rs1_id);
  assign rs2_match = use_rs2 && (rd_exe == rs2_id);

  assign load_hazard = late_result && (rd_exe != riscv_ctrl_pkg::REG_ZERO) &&
                       (rs1_match || rs2_match);

endmodule

/* design/pipeline_controller.sv */
`timescale 1ns/1ps

module pipeline_controller (
  input  logic                      stall_pipl,
  input  logic                      divide_stall,
  input  logic                      branch_hazard,
  input  logic                      load_hazard,
  output riscv_ctrl_pkg::pipe_ctrl_t pipe
);

  always_comb begin
    pipe            = '0;
    pipe.pc_en      = 1'b1;
    pipe.if_id_en   = 1'b1;
    pipe.id_exe_en  = 1'b1;
    pipe.exe_mem_en = 1'b1;
    pipe.mem_wb_en  = 1'b1;

    if (stall_pipl || divide_stall) begin
      // freeze every register
      pipe = '0;
    end else if (branch_hazard) begin
      // squash the three younger instructions
      pipe.if_id_clr   = 1'b1;
      pipe.id_exe_clr  = 1'b1;
      pipe.exe_mem_clr = 1'b1;
    end else if (load_hazard) begin
      // hold fetch and decode, insert a bubble into execute
      pipe.pc_en      = 1'b0;
      pipe.if_id_en   = 1'b0;
      pipe.id_exe_clr = 1'b1;
    end
  end

endmodule

/* design/riscv_ctrl_pkg.sv */
package riscv_ctrl_pkg;

  // rv32 base opcodes
  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_I      = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // fun7 of the M extension
  localparam logic [6:0] FUN7_MULDIV = 7'b0000001;
  localparam logic [4:0] REG_ZERO    = 5'd0;

  typedef enum logic [4:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU
  } alu_t;

  // branch kinds follow the fun3 encoding
  typedef enum logic [2:0] {
    BEQ  = 3'd0,
    BNE  = 3'd1,
    BLT  = 3'd4,
    BGE  = 3'd5,
    BLTU = 3'd6,
    BGEU = 3'd7
  } branch_t;

  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2,
    WB_CSR = 2'd3
  } wb_sel_t;

  typedef enum logic [1:0] {
    ALUOP_ADD    = 2'd0,
    ALUOP_BRANCH = 2'd1,
    ALUOP_R      = 2'd2,
    ALUOP_I      = 2'd3
  } alu_op_t;

  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_WB   = 2'd1,
    FWD_MEM  = 2'd2
  } fwd_sel_t;

  typedef struct packed {
    logic    reg_write;
    logic    mem_write;
    wb_sel_t mem_to_reg;
    logic    branch;
    logic    alu_src;
    logic    jump;
    logic    lui;
    logic    auipc;
    logic    jal;
    alu_op_t alu_op;
    logic    r_type;
    logic    csr_type;
  } decode_ctrl_t;

  typedef struct packed {
    logic     rd1_id;
    logic     rd2_id;
    fwd_sel_t rd1_exe;
    fwd_sel_t rd2_exe;
    logic     rd2_mem;
  } fwd_ctrl_t;

  typedef struct packed {
    logic pc_en;
    logic if_id_en;
    logic id_exe_en;
    logic exe_mem_en;
    logic mem_wb_en;
    logic if_id_clr;
    logic id_exe_clr;
    logic exe_mem_clr;
    logic mem_wb_clr;
  } pipe_ctrl_t;

endpackage

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_control_unit -f control_unit.f -o Vtb_control_unit

sim_out=$(./obj_dir/Vtb_control_unit 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "^TB PASSED$"; then
  exit 0
fi
exit 1

/* verif/control_unit_properties.sv */
`timescale 1ns/1ps

module control_unit_properties (
  input logic                       clk,
  input logic                       arst_n,
  input logic                       stall_pipl,
  input logic                       divide_stall,
  input logic                       load_hazard,
  input logic                       pc_sel_mem,
  input logic                       invalid_inst,
  input riscv_ctrl_pkg::pipe_ctrl_t pipe
);

  logic any_en;

  assign any_en = pipe.pc_en | pipe.if_id_en | pipe.id_exe_en | pipe.exe_mem_en | pipe.mem_wb_en;

  // back-pressure freezes every pipeline register
  stall_freezes_all: assert property (@(posedge clk) disable iff (!arst_n)
    (stall_pipl || divide_stall) |-> !any_en)
    else $error("pipeline enable high during a stall");

  invalid_low_in_reset: assert property (@(posedge clk) !arst_n |-> !invalid_inst)
    else $error("invalid_inst high while reset is asserted");

  // a lone load hazard holds fetch and bubbles execute
  load_bubble: assert property (@(posedge clk) disable iff (!arst_n)
    (load_hazard && !pc_sel_mem && !stall_pipl && !divide_stall) |->
      (!pipe.pc_en && !pipe.if_id_en && pipe.id_exe_clr))
    else $error("load hazard without the stall pattern");

endmodule

bind control_unit control_unit_properties props (
  .clk          (clk),
  .arst_n       (arst_n),
  .stall_pipl   (stall_pipl),
  .divide_stall (divide_stall),
  .load_hazard  (load_hazard),
  .pc_sel_mem   (pc_sel_mem),
  .invalid_inst (invalid_inst),
  .pipe         (pipe)
);

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset held over three rising edges, released on a falling edge
  initial begin
    arst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

/* verif/tb_control_unit.sv */
`timescale 1ns/1ps

module tb_control_unit;

  // the tests take about 150 cycles
  localparam int MAX_CYCLES = 400;

  // five enables, then four clears
  localparam riscv_ctrl_pkg::pipe_ctrl_t PIPE_RUN   = 9'b11111_0000;
  localparam riscv_ctrl_pkg::pipe_ctrl_t PIPE_FLUSH = 9'b11111_1110;
  localparam riscv_ctrl_pkg::pipe_ctrl_t PIPE_LOAD  = 9'b00111_0100;
  localparam riscv_ctrl_pkg::pipe_ctrl_t PIPE_HOLD  = 9'b00000_0000;
  localparam logic [6:0] OP_BAD = 7'b0000000;

  logic clk;
  logic por_n;
  logic rst_req_n;
  logic arst_n;
  logic [6:0] opcode_id;
  logic [6:0] fun7_exe;
  logic [2:0] fun3_exe;
  logic [2:0] fun3_mem;
  logic zero_mem, jump_mem, branch_mem, interrupt;
  logic divide_stall, stall_pipl;
  logic [4:0] rs1_id, rs2_id, rs1_exe, rs2_exe, rs2_mem;
  logic [4:0] rd_exe, rd_mem, rd_wb;
  logic reg_write_mem, reg_write_wb;
  riscv_ctrl_pkg::alu_op_t      alu_op_exe;
  riscv_ctrl_pkg::wb_sel_t      mem_to_reg_exe;
  riscv_ctrl_pkg::decode_ctrl_t dec;
  logic                         invalid_inst;
  riscv_ctrl_pkg::alu_t         alu_ctrl_exe;
  logic                         m_type_exe;
  logic                         divide_instruction;
  logic                         pc_sel_mem;
  riscv_ctrl_pkg::fwd_ctrl_t    fwd;
  logic                         load_hazard;
  riscv_ctrl_pkg::pipe_ctrl_t   pipe;

  int n_checks = 0;
  int n_errors = 0;
  logic [31:0] rng_state = 32'd50829;

  tb_clock_gen clk_gen (
    .clk    (clk),
    .arst_n (por_n)
  );

  // power-on reset plus a reset the tests can request
  assign arst_n = por_n & rst_req_n;

  control_unit uut (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // registers 0 to 3 only, so sources and destinations collide often
  function automatic logic [4:0] rand_reg();
    rng_state = xorshift(rng_state);
    return {3'b000, rng_state[1:0]};
  endfunction

  function automatic logic rand_bit();
    rng_state = xorshift(rng_state);
    return rng_state[7];
  endfunction

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp_v, act_v);
    end
  endtask

  task automatic check_decode(input string name, input riscv_ctrl_pkg::decode_ctrl_t exp_v,
                              input riscv_ctrl_pkg::decode_ctrl_t act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp_v, act_v);
    end
  endtask

  task automatic check_alu(input string name, input riscv_ctrl_pkg::alu_t exp_v,
                           input riscv_ctrl_pkg::alu_t act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("Mismatch %s: expected %s, actual %s", name, exp_v.name(), act_v.name());
    end
  endtask

  task automatic check_fwd(input string name, input riscv_ctrl_pkg::fwd_ctrl_t exp_v,
                           input riscv_ctrl_pkg::fwd_ctrl_t act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_pipe(input string name, input riscv_ctrl_pkg::pipe_ctrl_t exp_v,
                            input riscv_ctrl_pkg::pipe_ctrl_t act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp_v, act_v);
    end
  endtask

  task automatic idle_inputs();
    opcode_id      = riscv_ctrl_pkg::OP_R;
    fun7_exe       = 7'd0;
    fun3_exe       = 3'd0;
    fun3_mem       = 3'd0;
    alu_op_exe     = riscv_ctrl_pkg::ALUOP_ADD;
    zero_mem       = 1'b0;
    jump_mem       = 1'b0;
    branch_mem     = 1'b0;
    interrupt      = 1'b0;
    divide_stall   = 1'b0;
    stall_pipl     = 1'b0;
    rs1_id         = 5'd0;
    rs2_id         = 5'd0;
    rs1_exe        = 5'd0;
    rs2_exe        = 5'd0;
    rs2_mem        = 5'd0;
    rd_exe         = 5'd0;
    rd_mem         = 5'd0;
    rd_wb          = 5'd0;
    reg_write_mem  = 1'b0;
    reg_write_wb   = 1'b0;
    mem_to_reg_exe = riscv_ctrl_pkg::WB_ALU;
  endtask

  task automatic decode_one(input string name, input logic [6:0] op,
                            input riscv_ctrl_pkg::decode_ctrl_t exp_v);
    @(negedge clk);
    opcode_id = op;
    #1;
    check_decode(name, exp_v, dec);
  endtask

  // bits: rw mw wb br src jmp lui auipc jal aluop r csr
  task automatic test_decode();
    @(negedge clk);
    idle_inputs();
    decode_one("dec r",      riscv_ctrl_pkg::OP_R,      14'b1_0_00_0_0_0_0_0_0_10_1_0);
    decode_one("dec i",      riscv_ctrl_pkg::OP_I,      14'b1_0_00_0_1_0_0_0_0_11_0_0);
    decode_one("dec load",   riscv_ctrl_pkg::OP_LOAD,   14'b1_0_01_0_1_0_0_0_0_00_0_0);
    decode_one("dec store",  riscv_ctrl_pkg::OP_STORE,  14'b0_1_00_0_1_0_0_0_0_00_0_0);
    decode_one("dec branch", riscv_ctrl_pkg::OP_BRANCH, 14'b0_0_00_1_0_0_0_0_0_01_0_0);
    decode_one("dec jal",    riscv_ctrl_pkg::OP_JAL,    14'b1_0_10_0_0_1_0_0_1_00_0_0);
    decode_one("dec jalr",   riscv_ctrl_pkg::OP_JALR,   14'b1_0_10_0_1_1_0_0_0_00_0_0);
    decode_one("dec lui",    riscv_ctrl_pkg::OP_LUI,    14'b1_0_00_0_1_0_1_0_0_00_0_0);
    decode_one("dec auipc",  riscv_ctrl_pkg::OP_AUIPC,  14'b1_0_00_0_1_0_0_1_0_00_0_0);
    decode_one("dec system", riscv_ctrl_pkg::OP_SYSTEM, 14'b1_0_11_0_0_0_0_0_0_00_0_1);
    decode_one("dec undefined", OP_BAD,                 14'b0);
  endtask

  task automatic alu_one(input string name, input riscv_ctrl_pkg::alu_op_t op,
                         input logic [2:0] f3, input logic [6:0] f7,
                         input riscv_ctrl_pkg::alu_t exp_op, input logic exp_m,
                         input logic exp_div);
    @(negedge clk);
    alu_op_exe = op;
    fun3_exe   = f3;
    fun7_exe   = f7;
    #1;
    check_alu(name, exp_op, alu_ctrl_exe);
    check_bit({name, " m_type"}, exp_m, m_type_exe);
    check_bit({name, " divide"}, exp_div, divide_instruction);
  endtask

  task automatic test_alu();
    riscv_ctrl_pkg::alu_t base_ops [8];
    riscv_ctrl_pkg::alu_t md_ops [8];
    base_ops = '{riscv_ctrl_pkg::ADD, riscv_ctrl_pkg::SLL, riscv_ctrl_pkg::SLT,
                 riscv_ctrl_pkg::SLTU, riscv_ctrl_pkg::XOR, riscv_ctrl_pkg::SRL,
                 riscv_ctrl_pkg::OR, riscv_ctrl_pkg::AND};
    md_ops = '{riscv_ctrl_pkg::MUL, riscv_ctrl_pkg::MULH, riscv_ctrl_pkg::MULHSU,
               riscv_ctrl_pkg::MULHU, riscv_ctrl_pkg::DIV, riscv_ctrl_pkg::DIVU,
               riscv_ctrl_pkg::REM, riscv_ctrl_pkg::REMU};
    @(negedge clk);
    idle_inputs();
    for (int i = 0; i < 8; i++) begin
      alu_one($sformatf("r f3=%0d", i), riscv_ctrl_pkg::ALUOP_R, i[2:0], 7'b0000000,
              base_ops[i], 1'b0, 1'b0);
      // div and rem forms sit in the upper half of fun3
      alu_one($sformatf("muldiv f3=%0d", i), riscv_ctrl_pkg::ALUOP_R, i[2:0],
              riscv_ctrl_pkg::FUN7_MULDIV, md_ops[i], 1'b1, i >= 4);
      alu_one($sformatf("i f3=%0d", i), riscv_ctrl_pkg::ALUOP_I, i[2:0], 7'b0000000,
              base_ops[i], 1'b0, 1'b0);
      alu_one($sformatf("add f3=%0d", i), riscv_ctrl_pkg::ALUOP_ADD, i[2:0], 7'b0100000,
              riscv_ctrl_pkg::ADD, 1'b0, 1'b0);
    end
    alu_one("r sub", riscv_ctrl_pkg::ALUOP_R, 3'd0, 7'b0100000, riscv_ctrl_pkg::SUB, 1'b0, 1'b0);
    alu_one("r sra", riscv_ctrl_pkg::ALUOP_R, 3'd5, 7'b0100000, riscv_ctrl_pkg::SRA, 1'b0, 1'b0);
    alu_one("i addi", riscv_ctrl_pkg::ALUOP_I, 3'd0, 7'b0100000, riscv_ctrl_pkg::ADD, 1'b0, 1'b0);
    alu_one("i srai", riscv_ctrl_pkg::ALUOP_I, 3'd5, 7'b0100000, riscv_ctrl_pkg::SRA, 1'b0, 1'b0);
    alu_one("beq", riscv_ctrl_pkg::ALUOP_BRANCH, 3'd0, 7'd0, riscv_ctrl_pkg::SUB, 1'b0, 1'b0);
    alu_one("bne", riscv_ctrl_pkg::ALUOP_BRANCH, 3'd1, 7'd0, riscv_ctrl_pkg::SUB, 1'b0, 1'b0);
    alu_one("blt", riscv_ctrl_pkg::ALUOP_BRANCH, 3'd4, 7'd0, riscv_ctrl_pkg::SLT, 1'b0, 1'b0);
    alu_one("bge", riscv_ctrl_pkg::ALUOP_BRANCH, 3'd5, 7'd0, riscv_ctrl_pkg::SLT, 1'b0, 1'b0);
    alu_one("bltu", riscv_ctrl_pkg::ALUOP_BRANCH, 3'd6, 7'd0, riscv_ctrl_pkg::SLTU, 1'b0, 1'b0);
    alu_one("bgeu", riscv_ctrl_pkg::ALUOP_BRANCH, 3'd7, 7'd0, riscv_ctrl_pkg::SLTU, 1'b0, 1'b0);
  endtask

  task automatic branch_one(input string name, input riscv_ctrl_pkg::branch_t kind,
                            input logic br, input logic jmp, input logic z, input logic exp_v);
    @(negedge clk);
    fun3_mem   = kind;
    branch_mem = br;
    jump_mem   = jmp;
    zero_mem   = z;
    #1;
    check_bit(name, exp_v, pc_sel_mem);
    check_pipe(name, exp_v ? PIPE_FLUSH : PIPE_RUN, pipe);
  endtask

  task automatic test_branch();
    riscv_ctrl_pkg::branch_t kinds [6];
    logic exp_v;
    kinds = '{riscv_ctrl_pkg::BEQ, riscv_ctrl_pkg::BNE, riscv_ctrl_pkg::BLT,
              riscv_ctrl_pkg::BGE, riscv_ctrl_pkg::BLTU, riscv_ctrl_pkg::BGEU};
    @(negedge clk);
    idle_inputs();
    for (int k = 0; k < 6; k++) begin
      for (int z = 0; z < 2; z++) begin
        // equal and greater-or-equal forms are taken on a zero result
        exp_v = (kinds[k] inside {riscv_ctrl_pkg::BEQ, riscv_ctrl_pkg::BGE,
                                  riscv_ctrl_pkg::BGEU}) ? z[0] : !z[0];
        branch_one($sformatf("%s zero=%0d", kinds[k].name(), z), kinds[k], 1'b1, 1'b0,
                   z[0], exp_v);
      end
    end
    branch_one("jump", riscv_ctrl_pkg::BEQ, 1'b0, 1'b1, 1'b0, 1'b1);
    branch_one("no branch", riscv_ctrl_pkg::BEQ, 1'b0, 1'b0, 1'b1, 1'b0);
  endtask

  function automatic logic wb_hits(input logic [4:0] rs);
    return reg_write_wb && (rd_wb != 5'd0) && (rd_wb == rs);
  endfunction

  function automatic logic mem_hits(input logic [4:0] rs);
    return reg_write_mem && (rd_mem != 5'd0) && (rd_mem == rs);
  endfunction

  task automatic test_forwarding();
    riscv_ctrl_pkg::fwd_ctrl_t exp_v;
    @(negedge clk);
    idle_inputs();
    for (int n = 0; n < 40; n++) begin
      @(negedge clk);
      rs1_id        = rand_reg();
      rs2_id        = rand_reg();
      rs1_exe       = rand_reg();
      rs2_exe       = rand_reg();
      rs2_mem       = rand_reg();
      rd_mem        = rand_reg();
      rd_wb         = rand_reg();
      reg_write_mem = rand_bit();
      reg_write_wb  = rand_bit();
      #1;
      exp_v.rd1_id  = wb_hits(rs1_id);
      exp_v.rd2_id  = wb_hits(rs2_id);
      exp_v.rd1_exe = mem_hits(rs1_exe) ? riscv_ctrl_pkg::FWD_MEM :
                      wb_hits(rs1_exe) ? riscv_ctrl_pkg::FWD_WB : riscv_ctrl_pkg::FWD_NONE;
      exp_v.rd2_exe = mem_hits(rs2_exe) ? riscv_ctrl_pkg::FWD_MEM :
                      wb_hits(rs2_exe) ? riscv_ctrl_pkg::FWD_WB : riscv_ctrl_pkg::FWD_NONE;
      exp_v.rd2_mem = wb_hits(rs2_mem);
      check_fwd($sformatf("fwd %0d", n), exp_v, fwd);
    end
  endtask

  // press holds stall_pipl, divide_stall and jump_mem
  task automatic hazard_one(input string name, input logic [6:0] op, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [4:0] rd,
                            input riscv_ctrl_pkg::wb_sel_t src, input logic [2:0] press,
                            input logic exp_hz, input riscv_ctrl_pkg::pipe_ctrl_t exp_pipe);
    @(negedge clk);
    opcode_id      = op;
    rs1_id         = rs1;
    rs2_id         = rs2;
    rd_exe         = rd;
    mem_to_reg_exe = src;
    {stall_pipl, divide_stall, jump_mem} = press;
    #1;
    check_bit(name, exp_hz, load_hazard);
    check_pipe(name, exp_pipe, pipe);
  endtask

  task automatic test_hazard();
    @(negedge clk);
    idle_inputs();
    hazard_one("load rs1", riscv_ctrl_pkg::OP_R, 5'd5, 5'd6, 5'd5, riscv_ctrl_pkg::WB_MEM,
               3'b000, 1'b1, PIPE_LOAD);
    hazard_one("load rs2", riscv_ctrl_pkg::OP_R, 5'd6, 5'd5, 5'd5, riscv_ctrl_pkg::WB_MEM,
               3'b000, 1'b1, PIPE_LOAD);
    hazard_one("csr rs1", riscv_ctrl_pkg::OP_I, 5'd5, 5'd6, 5'd5, riscv_ctrl_pkg::WB_CSR,
               3'b000, 1'b1, PIPE_LOAD);
    hazard_one("store data", riscv_ctrl_pkg::OP_STORE, 5'd1, 5'd5, 5'd5, riscv_ctrl_pkg::WB_MEM,
               3'b000, 1'b1, PIPE_LOAD);
    hazard_one("x0 dest", riscv_ctrl_pkg::OP_R, 5'd0, 5'd0, 5'd0, riscv_ctrl_pkg::WB_MEM,
               3'b000, 1'b0, PIPE_RUN);
    hazard_one("lui no rs1", riscv_ctrl_pkg::OP_LUI, 5'd5, 5'd6, 5'd5, riscv_ctrl_pkg::WB_MEM,
               3'b000, 1'b0, PIPE_RUN);
    hazard_one("addi no rs2", riscv_ctrl_pkg::OP_I, 5'd6, 5'd5, 5'd5, riscv_ctrl_pkg::WB_MEM,
               3'b000, 1'b0, PIPE_RUN);
    hazard_one("alu result", riscv_ctrl_pkg::OP_R, 5'd5, 5'd6, 5'd5, riscv_ctrl_pkg::WB_ALU,
               3'b000, 1'b0, PIPE_RUN);
    hazard_one("stall over load", riscv_ctrl_pkg::OP_R, 5'd5, 5'd6, 5'd5, riscv_ctrl_pkg::WB_MEM,
               3'b100, 1'b1, PIPE_HOLD);
    hazard_one("divide over load", riscv_ctrl_pkg::OP_R, 5'd5, 5'd6, 5'd5, riscv_ctrl_pkg::WB_MEM,
               3'b010, 1'b1, PIPE_HOLD);
    hazard_one("jump over load", riscv_ctrl_pkg::OP_R, 5'd5, 5'd6, 5'd5, riscv_ctrl_pkg::WB_MEM,
               3'b001, 1'b1, PIPE_FLUSH);
    hazard_one("stall over jump", riscv_ctrl_pkg::OP_R, 5'd1, 5'd2, 5'd3, riscv_ctrl_pkg::WB_ALU,
               3'b101, 1'b0, PIPE_HOLD);
  endtask

  task automatic test_invalid();
    @(negedge clk);
    idle_inputs();
    opcode_id = OP_BAD;
    #1;
    check_bit("inv before edge", 1'b0, invalid_inst);
    @(negedge clk);
    opcode_id = riscv_ctrl_pkg::OP_R;
    #1;
    check_bit("inv set", 1'b1, invalid_inst);
    repeat (3) begin
      @(negedge clk);
      #1;
      check_bit("inv holds", 1'b1, invalid_inst);
    end
    @(negedge clk);
    interrupt = 1'b1;
    @(negedge clk);
    interrupt = 1'b0;
    #1;
    check_bit("inv cleared by interrupt", 1'b0, invalid_inst);
    @(negedge clk);
    opcode_id = OP_BAD;
    @(negedge clk);
    opcode_id = riscv_ctrl_pkg::OP_R;
    #1;
    check_bit("inv set before jump", 1'b1, invalid_inst);
    @(negedge clk);
    jump_mem = 1'b1;
    @(negedge clk);
    jump_mem = 1'b0;
    #1;
    check_bit("inv cleared by jump", 1'b0, invalid_inst);
    // undefined opcode squashed by a load bubble, then held by a stall
    @(negedge clk);
    opcode_id      = OP_BAD;
    rs1_id         = 5'd7;
    rd_exe         = 5'd7;
    mem_to_reg_exe = riscv_ctrl_pkg::WB_MEM;
    @(negedge clk);
    mem_to_reg_exe = riscv_ctrl_pkg::WB_ALU;
    stall_pipl     = 1'b1;
    #1;
    check_bit("inv low on id_exe clear", 1'b0, invalid_inst);
    @(negedge clk);
    stall_pipl = 1'b0;
    interrupt  = 1'b1;
    #1;
    check_bit("inv low on stall", 1'b0, invalid_inst);
    @(negedge clk);
    interrupt = 1'b0;
    #1;
    check_bit("inv clear beats set", 1'b0, invalid_inst);
    @(negedge clk);
    opcode_id = riscv_ctrl_pkg::OP_R;
    #1;
    check_bit("inv set again", 1'b1, invalid_inst);
    @(negedge clk);
    rst_req_n = 1'b0;
    #1;
    check_bit("inv low in reset", 1'b0, invalid_inst);
    @(negedge clk);
    rst_req_n = 1'b1;
    #1;
    check_bit("inv low after reset", 1'b0, invalid_inst);
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    rst_req_n = 1'b1;
    idle_inputs();
    wait (por_n === 1'b1);
    @(negedge clk);
    #1;
    check_bit("inv after power-on reset", 1'b0, invalid_inst);
    test_decode();
    test_alu();
    test_branch();
    test_forwarding();
    test_hazard();
    test_invalid();
    $display("checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
